// File: Makefile
# Verilator build and run of the AES SubBytes unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 \
		--timescale 1ns/1ps \
		--top-module aes_sub_unit_tb \
		-Mdir obj_dir \
		-f compile.f
	./obj_dir/Vaes_sub_unit_tb +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
logic/aes_sub_pkg.sv
logic/aes_sub_operand_gather.sv
logic/aes_sbox_lane.sv
logic/aes_sub_result_assembler.sv
logic/aes_sub_unit.sv
tests/aes_sub_unit_sva.sv
tests/aes_sub_unit_tb.sv

// File: logic/aes_sbox_lane.sv
module aes_sbox_lane (
        input  aes_sub_pkg::byte_t in_byte,
        input  logic               inv,
        output aes_sub_pkg::byte_t out_byte
);
        import aes_sub_pkg::*;

        byte_t pre_affine;
        byte_t field_inv;
        byte_t post_affine;

        // Inverse direction undoes the affine step before inverting
        always_comb begin
                if (inv) begin
                        pre_affine = sbox_affine_inv(in_byte);
                end else begin
                        pre_affine = in_byte;
                end
        end

        assign field_inv = gf_inv(pre_affine); // Shared by both directions

        assign post_affine = sbox_affine(field_inv);

        assign out_byte = inv ? field_inv : post_affine;

endmodule

// File: logic/aes_sub_operand_gather.sv
module aes_sub_operand_gather (
        input  logic                    clock,
        input  logic                    reset,
        input  logic                    valid,
        input  logic                    enc,
        input  logic                    rot,
        input  aes_sub_pkg::word_t      rs1,
        input  aes_sub_pkg::word_t      rs2,
        output aes_sub_pkg::sub_stage_t stage
);
        import aes_sub_pkg::*;

        lane_bytes_t picked;

        // Byte i of lane i, alternating rs1 and rs2
        always_comb begin
                for (int i = 0; i < LANES; i++) begin
                        if (i % 2 == 0) begin
                                picked[i] = rs1[i*BYTE_W +: BYTE_W]; // Lanes 0 and 2
                        end else begin
                                picked[i] = rs2[i*BYTE_W +: BYTE_W]; // Lanes 1 and 3
                        end
                end
        end

        always_ff @(posedge clock) begin
                if (valid) begin
                        stage.ctrl.inv <= ~enc; // Decrypt uses inverse S-box
                        stage.ctrl.rot <= rot;
                        stage.bytes    <= picked;
                end
                if (reset) begin
                        stage.ctrl.valid <= 1'b0;
                end else begin
                        stage.ctrl.valid <= valid;
                end
        end

endmodule

// File: logic/aes_sub_pkg.sv
package aes_sub_pkg;

        localparam int BYTE_W = 8;
        localparam int WORD_W = 32;
        localparam int LANES  = 4;

        // Low byte of the field polynomial 0x11b
        localparam logic [BYTE_W-1:0] GF_POLY_LOW  = 8'h1b;
        localparam logic [BYTE_W-1:0] AFFINE_C     = 8'h63;
        localparam logic [BYTE_W-1:0] AFFINE_INV_C = 8'h05;

        typedef logic [BYTE_W-1:0] byte_t;
        typedef logic [WORD_W-1:0] word_t;

        // Lane 0 sits in the low byte
        typedef byte_t [LANES-1:0] lane_bytes_t;

        typedef struct packed {
                logic valid; // Stage holds an operation
                logic inv;   // Inverse S-box
                logic rot;   // Rotate result left one byte
        } sub_ctrl_t;

        typedef struct packed {
                sub_ctrl_t   ctrl;
                lane_bytes_t bytes;
        } sub_stage_t;

        // Multiply by x, reducing modulo 0x11b
        function automatic byte_t gf_xtime(byte_t a);
                byte_t shifted;
                shifted = {a[BYTE_W-2:0], 1'b0};
                if (a[BYTE_W-1]) begin
                        shifted = shifted ^ GF_POLY_LOW;
                end
                return shifted;
        endfunction

        // Shift-and-add multiply in GF(2^8)
        function automatic byte_t gf_mul(byte_t a, byte_t b);
                byte_t acc;
                byte_t partial;
                acc     = '0;
                partial = a;
                for (int i = 0; i < BYTE_W; i++) begin
                        if (b[i]) begin
                                acc = acc ^ partial;
                        end
                        partial = gf_xtime(partial);
                end
                return acc;
        endfunction

        // a^254 equals a^-1 for nonzero a, and zero stays zero
        function automatic byte_t gf_inv(byte_t a);
                byte_t square;
                byte_t acc;
                square = a;
                acc    = 8'h01;
                // 254 = 2 + 4 + 8 + 16 + 32 + 64 + 128
                for (int k = 1; k < BYTE_W; k++) begin
                        square = gf_mul(square, square);
                        acc    = gf_mul(acc, square);
                end
                return acc;
        endfunction

        function automatic byte_t byte_rotl(byte_t a, int unsigned n);
                byte_t rotated;
                rotated = (a << n) | (a >> (BYTE_W - n));
                return rotated;
        endfunction

        // b[i] = x[i] ^ x[i+4] ^ x[i+5] ^ x[i+6] ^ x[i+7] ^ c[i]
        function automatic byte_t sbox_affine(byte_t x);
                byte_t y;
                y = x ^ byte_rotl(x, 1) ^ byte_rotl(x, 2) ^
                    byte_rotl(x, 3) ^ byte_rotl(x, 4);
                return y ^ AFFINE_C;
        endfunction

        // x[i] = b[i+2] ^ b[i+5] ^ b[i+7] ^ d[i]
        function automatic byte_t sbox_affine_inv(byte_t b);
                byte_t y;
                y = byte_rotl(b, 1) ^ byte_rotl(b, 3) ^ byte_rotl(b, 6);
                return y ^ AFFINE_INV_C;
        endfunction

endpackage

// File: logic/aes_sub_result_assembler.sv
module aes_sub_result_assembler (
        input  logic                   clock,
        input  logic                   reset,
        input  aes_sub_pkg::sub_ctrl_t ctrl,
        input  aes_sub_pkg::lane_bytes_t lane_out,
        output logic                   ready,
        output aes_sub_pkg::word_t     result
);
        import aes_sub_pkg::*;

        word_t in_order;
        word_t rotated;
        word_t next_result;

        assign in_order = lane_out; // Lane 0 in low byte

        // Lanes 2,1,0,3 from high byte to low
        assign rotated = {in_order[WORD_W-BYTE_W-1:0], in_order[WORD_W-1 -: BYTE_W]};

        assign next_result = ctrl.rot ? rotated : in_order;

        always_ff @(posedge clock) begin
                if (reset) begin
                        ready  <= 1'b0;
                        result <= '0;
                end else begin
                        ready <= ctrl.valid;
                        if (ctrl.valid) begin
                                result <= next_result; // Holds while idle
                        end
                end
        end

endmodule

// File: logic/aes_sub_unit.sv
module aes_sub_unit (
        input  logic               clock,
        input  logic               reset,
        input  logic               valid,
        input  logic               enc,
        input  logic               rot,
        input  aes_sub_pkg::word_t rs1,
        input  aes_sub_pkg::word_t rs2,
        output logic               ready,
        output aes_sub_pkg::word_t result
);
        import aes_sub_pkg::*;

        sub_stage_t  gather_out;
        lane_bytes_t lane_out;

        // Stage 1 registers the selected bytes
        aes_sub_operand_gather u_gather (
                .clock (clock),
                .reset (reset),
                .valid (valid),
                .enc   (enc),
                .rot   (rot),
                .rs1   (rs1),
                .rs2   (rs2),
                .stage (gather_out)
        );

        // Field inversion between the two registers
        genvar g;
        generate
                for (g = 0; g < LANES; g++) begin : g_lane
                        aes_sbox_lane u_lane (
                                .in_byte  (gather_out.bytes[g]),
                                .inv      (gather_out.ctrl.inv),
                                .out_byte (lane_out[g])
                        );
                end
        endgenerate

        // Stage 2 registers the packed word
        aes_sub_result_assembler u_assembler (
                .clock    (clock),
                .reset    (reset),
                .ctrl     (gather_out.ctrl),
                .lane_out (lane_out),
                .ready    (ready),
                .result   (result)
        );

endmodule

// File: tests/aes_sub_unit_sva.sv
module aes_sub_unit_sva (
        input logic               clock,
        input logic               reset,
        input logic               valid,
        input logic               enc,
        input logic               rot,
        input aes_sub_pkg::word_t rs1,
        input aes_sub_pkg::word_t rs2,
        input logic               ready,
        input aes_sub_pkg::word_t result
);
        timeunit 1ns;
        timeprecision 1ps;
        import aes_sub_pkg::*;

        localparam byte_t AFFINE_CONST = 8'h63;

        typedef struct packed {
                logic  valid;
                logic  enc;
                logic  rot;
                word_t rs1;
                word_t rs2;
        } op_t;

        byte_t sbox_tab [256];
        byte_t inv_sbox_tab [256];
        op_t   cur_op;
        op_t   hist_d1;         // Operation sampled one edge ago
        op_t   hist_d2;         // Two edges ago
        logic  expected_ready;
        word_t expected_result;
        word_t prev_result;
        logic  prev_reset;
        logic  check_failed = 1'b0;

        // Carry-less product, then reduce by 0x11b from the top bit down
        function automatic byte_t field_mul(byte_t a, byte_t b);
                logic [14:0] prod;
                prod = '0;
                for (int i = 0; i < 8; i++) begin
                        if (b[3'(i)]) begin
                                prod = prod ^ (15'(a) << i);
                        end
                end
                for (int i = 14; i >= 8; i--) begin
                        if (prod[4'(i)]) begin
                                prod = prod ^ (15'h11b << (i - 8));
                        end
                end
                return prod[7:0];
        endfunction

        function automatic byte_t find_inverse(byte_t a);
                byte_t found;
                found = 8'h00; // Zero has no inverse and maps to zero
                for (int c = 1; c < 256; c++) begin
                        if (a != 8'h00 && field_mul(a, 8'(c)) == 8'h01) begin
                                found = 8'(c);
                        end
                end
                return found;
        endfunction

        function automatic byte_t affine_rule(byte_t x);
                byte_t y;
                for (int i = 0; i < 8; i++) begin
                        y[3'(i)] = x[3'(i)] ^ x[3'(i + 4)] ^ x[3'(i + 5)] ^ x[3'(i + 6)] ^
                                   x[3'(i + 7)] ^ AFFINE_CONST[3'(i)];
                end
                return y;
        endfunction

        function automatic byte_t substitute(logic fwd, byte_t b);
                return fwd ? sbox_tab[b] : inv_sbox_tab[b];
        endfunction

        function automatic word_t model_word(op_t op);
                word_t sub_word;
                sub_word = {substitute(op.enc, op.rs2[31:24]), substitute(op.enc, op.rs1[23:16]),
                            substitute(op.enc, op.rs2[15:8]), substitute(op.enc, op.rs1[7:0])};
                if (op.rot) begin
                        sub_word = {sub_word[23:0], sub_word[31:24]}; // Left by one byte
                end
                return sub_word;
        endfunction

        // Inverse table comes from inverting the forward table
        initial begin
                for (int v = 0; v < 256; v++) begin
                        sbox_tab[8'(v)] = affine_rule(find_inverse(8'(v)));
                end
                for (int v = 0; v < 256; v++) begin
                        inv_sbox_tab[sbox_tab[8'(v)]] = 8'(v);
                end
        end

        assign cur_op = {valid, enc, rot, rs1, rs2};

        always_ff @(posedge clock) begin
                hist_d1 <= cur_op;
                hist_d2 <= hist_d1;
                if (reset) begin
                        hist_d1.valid <= 1'b0;
                        hist_d2.valid <= 1'b0;
                end
                prev_result <= result;
                prev_reset  <= reset;
        end

        assign expected_ready = hist_d2.valid;

        always_comb begin
                expected_result = model_word(hist_d2);
        end

        ready_tracks_valid: assert property (@(posedge clock) disable iff (reset)
                ready == expected_ready)
                else begin
                        $error("FAILED t=%0t ready expected %0b actual %0b",
                               $time, $sampled(expected_ready), $sampled(ready));
                        check_failed = 1'b1;
                end

        result_matches_model: assert property (@(posedge clock) disable iff (reset)
                expected_ready |-> result == expected_result)
                else begin
                        $error("FAILED t=%0t result expected %08h actual %08h",
                               $time, $sampled(expected_result), $sampled(result));
                        check_failed = 1'b1;
                end

        result_holds_when_idle: assert property (@(posedge clock) disable iff (reset)
                !ready |-> result == prev_result)
                else begin
                        $error("FAILED t=%0t result expected %08h actual %08h",
                               $time, $sampled(prev_result), $sampled(result));
                        check_failed = 1'b1;
                end

        clear_after_reset: assert property (@(posedge clock)
                (prev_reset && !reset) |-> (!ready && result == '0))
                else begin
                        $error("FAILED t=%0t ready/result expected 0/%08h actual %0b/%08h",
                               $time, 32'h0, $sampled(ready), $sampled(result));
                        check_failed = 1'b1;
                end

endmodule

bind aes_sub_unit aes_sub_unit_sva u_sva (
        .clock  (clock),
        .reset  (reset),
        .valid  (valid),
        .enc    (enc),
        .rot    (rot),
        .rs1    (rs1),
        .rs2    (rs2),
        .ready  (ready),
        .result (result)
);

// File: tests/aes_sub_unit_tb.sv
module aes_sub_unit_tb;
        timeunit 1ns;
        timeprecision 1ps;
        import aes_sub_pkg::*;

        localparam int CLOCK_PERIOD  = 4;
        localparam int RESET_CYCLES  = 16;
        localparam int RANDOM_CYCLES = 2000;
        localparam int BUDGET_CYCLES = RESET_CYCLES + 3000;

        logic  clock = 1'b0;
        logic  reset = 1'b1;
        logic  valid = 1'b0;
        logic  enc   = 1'b0;
        logic  rot   = 1'b0;
        word_t rs1   = '0;
        word_t rs2   = '0;
        logic  ready;
        word_t result;
        logic  done     = 1'b0;
        logic  reported = 1'b0;
        word_t patterns [4];

        always #(CLOCK_PERIOD / 2) clock = ~clock;

        aes_sub_unit u_aes_sub_unit (
                .clock  (clock),
                .reset  (reset),
                .valid  (valid),
                .enc    (enc),
                .rot    (rot),
                .rs1    (rs1),
                .rs2    (rs2),
                .ready  (ready),
                .result (result)
        );

        task automatic apply_op(input logic op_valid, input logic op_enc, input logic op_rot,
                                input word_t a, input word_t b);
                @(posedge clock);
                valid <= op_valid;
                enc   <= op_enc;
                rot   <= op_rot;
                rs1   <= a;
                rs2   <= b;
        endtask

        task automatic idle_cycles(input int n);
                repeat (n) begin
                        apply_op(1'b0, enc, rot, rs1, rs2);
                end
        endtask

        // Outputs are read at the falling edge, away from the register updates
        task automatic wait_for_ready(output word_t captured);
                do begin
                        @(negedge clock);
                end while (!ready);
                captured = result;
        endtask

        // Every pattern pair under each enc/rot setting, back to back
        task automatic directed_sweep();
                for (int combo = 0; combo < 4; combo++) begin
                        for (int i = 0; i < 4; i++) begin
                                for (int j = 0; j < 4; j++) begin
                                        apply_op(1'b1, combo[0], combo[1], patterns[i],
                                                 patterns[j]);
                                end
                        end
                        idle_cycles(3);
                end
        endtask

        // Forward result fed back through the inverse direction
        task automatic round_trip_pairs();
                word_t a;
                word_t b;
                word_t fwd;
                word_t back;
                word_t expected_back;
                for (int n = 0; n < 16; n++) begin
                        a = $urandom;
                        b = $urandom;
                        apply_op(1'b1, 1'b1, 1'b0, a, b);
                        apply_op(1'b0, 1'b1, 1'b0, a, b);
                        wait_for_ready(fwd);
                        apply_op(1'b1, 1'b0, 1'b0, fwd, fwd); // Same bytes back in place
                        apply_op(1'b0, 1'b0, 1'b0, fwd, fwd);
                        wait_for_ready(back);
                        expected_back = {b[31:24], a[23:16], b[15:8], a[7:0]};
                        assert (back == expected_back) else begin
                                $error("FAILED t=%0t result expected %08h actual %08h",
                                       $time, expected_back, back);
                                reported = 1'b1;
                                $display("STATUS: FAIL");
                                $fatal(1, "forward then inverse did not give back the bytes");
                        end
                end
        endtask

        task automatic random_traffic();
                int   burst_left;
                logic next_valid;
                burst_left = 0;
                for (int n = 0; n < RANDOM_CYCLES; n++) begin
                        if (burst_left > 0) begin
                                next_valid = 1'b1;
                                burst_left--;
                        end else if ($urandom % 16 == 0) begin
                                burst_left = 4 + int'($urandom % 8); // Back-to-back run
                                next_valid = 1'b1;
                        end else begin
                                next_valid = 1'($urandom % 2);
                        end
                        apply_op(next_valid, 1'($urandom % 2), 1'($urandom % 2),
                                 $urandom, $urandom);
                end
        endtask

        initial begin
                void'($urandom(32'h6e61));
                patterns[0] = 32'h0000_0000;
                patterns[1] = 32'hffff_ffff;
                patterns[2] = 32'h5353_5353;
                patterns[3] = 32'h6363_6363;
                repeat (RESET_CYCLES) @(posedge clock);
                reset <= 1'b0;
                idle_cycles(2);
                directed_sweep();
                idle_cycles(4);
                round_trip_pairs();
                idle_cycles(4);
                random_traffic();
                idle_cycles(4);
                @(negedge clock);
                if (u_aes_sub_unit.u_sva.check_failed) begin
                        reported = 1'b1;
                        $display("STATUS: FAIL");
                        $fatal(1, "a checker assertion failed during the run");
                end else begin
                        done = 1'b1;
                        $display("STATUS: PASS");
                        $finish;
                end
        end

        // Stop at the first assertion failure of the bound checker
        always @(negedge clock) begin
                if (u_aes_sub_unit.u_sva.check_failed && !reported) begin
                        reported = 1'b1;
                        $display("STATUS: FAIL");
                        $fatal(1, "checker assertion failed, stopping at the first error");
                end
        end

        initial begin
                #(BUDGET_CYCLES * CLOCK_PERIOD * 2); // Twice the expected run length
                reported = 1'b1;
                $display("STATUS: FAIL");
                $fatal(1, "watchdog expired before the tests finished");
        end

        final begin
                if (!done && !reported) begin
                        $display("STATUS: FAIL");
                end
        end

endmodule
